//--- build.f
rtl/taec_pkg.sv
rtl/ni_bus_capture.sv
rtl/ni_cmd_decode.sv
rtl/hv_channel_ctrl.sv
rtl/sense_ctrl.sv
rtl/readback_mux.sv
rtl/taec_top.sv
testbench/tb_taec_top.sv

//--- testbench/tb_taec_top.sv
`timescale 1ns/10ps

module tb_taec_top;

	import taec_pkg::*;

	localparam logic [BRD_SEL_W-1:0] BOARD_ID = 2'b10; // strapped id of the DUT
	localparam int HV_TIMEOUT = 6;                    // cycles allowed for a trip

	logic                 CLK1;
	logic                 rst_i;
	logic [BYTE_W-1:0]    addr_i;
	logic                 cs_i;
	logic                 ale_i;
	logic [BRD_SEL_W-1:0] mod_sel_i;
	logic [BRD_SEL_W-1:0] brd_id_i;
	logic [NUM_CHAN-1:0]  ht_i;
	logic                 swin_i;
	wire  [DOUT_W-1:0]    dout_o;
	logic [NUM_CHAN-1:0]  hv_en_n_o;
	logic                 hvon_n_o;
	logic                 hi_gain_n_o;
	logic [MUX_SEL_W-1:0] mux_dout_o;

	logic [31:0]          lfsr_state;   // random source
	logic                 exp_hvon;     // model of the control state
	logic                 exp_gain;
	logic [CHAN_W-1:0]    exp_idx;
	logic [NUM_CHAN-1:0]  exp_en;
	logic [NUM_CHAN-1:0]  exp_alarm;

	taec_top taec_top_i (
		.CLK1       (CLK1),
		.rst_i      (rst_i),
		.addr_i     (addr_i),
		.cs_i       (cs_i),
		.ale_i      (ale_i),
		.mod_sel_i  (mod_sel_i),
		.brd_id_i   (brd_id_i),
		.ht_i       (ht_i),
		.swin_i     (swin_i),
		.dout_o     (dout_o),
		.hv_en_n_o  (hv_en_n_o),
		.hvon_n_o   (hvon_n_o),
		.hi_gain_n_o(hi_gain_n_o),
		.mux_dout_o (mux_dout_o)
	);

	always #10 CLK1 = ~CLK1; // 20 ns period

	// ----------------------------------------
	// failure reporting and compare
	// ----------------------------------------
	task automatic stop_with_failure();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	// ----------------------------------------
	// random bits from x^32+x^22+x^2+x+1
	// ----------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state); // one step per bit
			value      = {value[30:0], lfsr_state[0]};
		end
	endtask

	// ----------------------------------------
	// expected values from the table and word rules
	// ----------------------------------------
	function automatic logic [MUX_SEL_W-1:0] mux_table_entry(input logic [CHAN_W-1:0] n);
		logic [CHAN_W-1:0] m;
		logic [2:0]        bank;
		logic [2:0]        low;
		m = (n < 24) ? n : 5'd0; // spare indexes act as 0
		case (m / 8)
			0:       bank = 3'b001;
			1:       bank = 3'b010;
			default: bank = 3'b100;
		endcase
		low = 7 - (m % 8); // channels count down
		return {bank, low};
	endfunction

	function automatic logic [DOUT_W-1:0] status_word();
		return {1'b0, 3'b001, exp_hvon, exp_gain, 1'b0, exp_idx};
	endfunction

	function automatic logic [DOUT_W-1:0] alarm_word(input logic [7:0] code);
		case (code)
			CMD_RD_HT1: return {1'b0, 3'b011, exp_alarm[7:0]};
			CMD_RD_HT2: return {1'b0, 3'b011, exp_alarm[15:8]};
			default:    return {1'b0, 3'b011, 3'b000, swin_i, exp_alarm[19:16]};
		endcase
	endfunction

	// ----------------------------------------
	// waits with their own limits
	// ----------------------------------------
	task automatic wait_dout_driven(input int limit, output int waited);
		waited = 0;
		do begin
			@(negedge CLK1);
			waited++;
		end while (dout_o === {DOUT_W{1'bz}} && waited < limit);
		if (dout_o === {DOUT_W{1'bz}}) begin
			$display("dout_o stayed high impedance although the board was selected");
			stop_with_failure();
		end
	endtask

	task automatic wait_hv_en(input logic [NUM_CHAN-1:0] expected);
		int n;
		n = 0;
		while (hv_en_n_o !== expected && n < HV_TIMEOUT) begin
			@(negedge CLK1);
			n++;
		end
		if (hv_en_n_o !== expected) begin
			$display("hv_en_n_o did not reach %h within %0d cycles", expected, HV_TIMEOUT);
			stop_with_failure();
		end
	endtask

	// ----------------------------------------
	// ni bus cycles
	// ----------------------------------------
	task automatic bus_write(input logic [7:0] code, input logic [7:0] data);
		@(negedge CLK1);
		cs_i   = 1'b1;
		ale_i  = 1'b1;
		addr_i = code;
		repeat (2) @(negedge CLK1); // address phase
		ale_i  = 1'b0;
		addr_i = data;
		repeat (4) @(negedge CLK1); // data phase
		cs_i   = 1'b0;
		addr_i = '0;
	endtask

	task automatic bus_read(input logic [7:0] code, input logic selected,
			output logic [DOUT_W-1:0] word);
		int waited;
		@(negedge CLK1);
		cs_i   = 1'b1;
		ale_i  = 1'b1;
		addr_i = code;
		waited = 0;
		if (selected) begin
			wait_dout_driven(2, waited); // counts toward the address phase
		end
		while (waited < 2) begin
			@(negedge CLK1);
			if (!selected) check_value("dout_o", {DOUT_W{1'bz}}, dout_o);
			waited++;
		end
		ale_i  = 1'b0;
		addr_i = 8'h00;
		for (int i = 0; i < 4; i++) begin
			@(negedge CLK1);
			if (!selected) check_value("dout_o", {DOUT_W{1'bz}}, dout_o);
		end
		word   = dout_o; // read word registered two edges after the data byte
		cs_i   = 1'b0;
		addr_i = '0;
	endtask

	task automatic read_and_check(input logic [7:0] code, input logic [DOUT_W-1:0] expected);
		logic [DOUT_W-1:0] w;
		bus_read(code, 1'b1, w);
		check_value("dout_o", expected, w);
	endtask

	task automatic check_pins();
		check_value("hvon_n_o", {~exp_hvon}, hvon_n_o);
		check_value("hi_gain_n_o", {~exp_gain}, hi_gain_n_o);
		check_value("hv_en_n_o", {~exp_en}, hv_en_n_o);
		check_value("mux_dout_o", mux_table_entry(exp_idx), mux_dout_o);
	endtask

	task automatic write_chan(input logic [CHAN_W-1:0] ch, input logic en);
		logic [31:0] r;
		take_bits(2, r); // pad bits must not matter
		bus_write(CMD_CHAN_EN, {en, r[1:0], ch});
		if (ch < NUM_CHAN) begin
			exp_en[ch] = en;
			if (en) exp_alarm[ch] = 1'b0; // re-enable clears the alarm
		end
		check_pins();
	endtask

	task automatic pulse_trip(input int ch);
		@(negedge CLK1);
		ht_i[ch] = 1'b1;
		@(negedge CLK1);
		ht_i[ch] = 1'b0;
		if (exp_en[ch]) begin
			exp_en[ch]    = 1'b0;
			exp_alarm[ch] = 1'b1;
		end
		wait_hv_en({~exp_en});
	endtask

	task automatic write_mux(input logic [CHAN_W-1:0] idx);
		logic [31:0] r;
		take_bits(3, r);
		bus_write(CMD_ADC_MUX, {r[2:0], idx}); // upper bits ignored
		exp_idx = (idx < NUM_MUX_IN) ? idx : 5'd0;
		check_value("mux_dout_o", mux_table_entry(idx), mux_dout_o);
		read_and_check(CMD_RD_STAT, status_word());
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic test_reset();
		check_value("hvon_n_o", 1'b1, hvon_n_o);
		check_value("hv_en_n_o", {NUM_CHAN{1'b1}}, hv_en_n_o);
		check_value("hi_gain_n_o", 1'b1, hi_gain_n_o);
		check_value("mux_dout_o", 6'b001111, mux_dout_o);
		check_value("dout_o", {DOUT_W{1'bz}}, dout_o); // cs_i low
	endtask

	task automatic test_hv_gain();
		logic [31:0] r;
		for (int v = 1; v >= 0; v--) begin
			take_bits(7, r);
			bus_write(CMD_HVON, {r[6:0], v[0]});
			exp_hvon = v[0];
			check_pins();
			take_bits(7, r);
			bus_write(CMD_GAIN, {r[6:0], v[0]});
			exp_gain = v[0];
			check_pins();
			read_and_check(CMD_RD_STAT, status_word());
		end
	endtask

	task automatic test_adc_mux();
		logic [31:0] r;
		int          spare_seen;
		spare_seen = 0;
		for (int i = 0; i < 16; i++) begin
			take_bits(5, r);
			if (r[4:0] >= NUM_MUX_IN) spare_seen++;
			write_mux(r[4:0]);
		end
		if (spare_seen == 0) write_mux(5'd30); // force one out-of-range index
	endtask

	task automatic test_channels();
		logic [31:0] r;
		write_chan(5'd0, 1'b1);
		write_chan(5'd7, 1'b1);
		write_chan(5'd12, 1'b1);
		write_chan(5'd19, 1'b1);
		pulse_trip(2); // trip on a disabled channel sets no alarm
		take_bits(5, r);
		write_chan(5'(3 + r[4:0] % 16), 1'b1); // keeps clear of channel 2
		swin_i = 1'b1;
		pulse_trip(12);
		pulse_trip(19);
		read_and_check(CMD_RD_HT1, alarm_word(CMD_RD_HT1));
		read_and_check(CMD_RD_HT2, alarm_word(CMD_RD_HT2));
		read_and_check(CMD_RD_HT3, alarm_word(CMD_RD_HT3));
		write_chan(5'd12, 1'b1); // re-enable after the trip
		read_and_check(CMD_RD_HT2, alarm_word(CMD_RD_HT2));
		write_chan(5'd7, 1'b0);
		take_bits(3, r);
		write_chan(5'd20 + r[2:0], 1'b1); // out of range
		write_chan(5'd31, 1'b1);
		swin_i = 1'b0;
		read_and_check(CMD_RD_HT1, alarm_word(CMD_RD_HT1));
		read_and_check(CMD_RD_HT3, alarm_word(CMD_RD_HT3));
	endtask

	task automatic test_board_select();
		logic [DOUT_W-1:0] w;
		@(negedge CLK1);
		mod_sel_i = ~BOARD_ID; // another board
		bus_write(CMD_HVON, {7'h00, ~exp_hvon});
		bus_write(CMD_GAIN, {7'h00, ~exp_gain});
		bus_write(CMD_ADC_MUX, {3'b000, 5'((exp_idx + 5) % NUM_MUX_IN)});
		bus_write(CMD_CHAN_EN, {1'b1, 2'b00, 5'd7}); // channel 7 is off here
		check_pins();
		bus_read(CMD_RD_STAT, 1'b0, w);
		@(negedge CLK1);
		mod_sel_i = BOARD_ID;
		read_and_check(CMD_RD_STAT, status_word());
	endtask

	initial begin
		CLK1       = 1'b0;
		rst_i      = 1'b1;
		addr_i     = '0;
		cs_i       = 1'b0;
		ale_i      = 1'b0;
		mod_sel_i  = BOARD_ID;
		brd_id_i   = BOARD_ID;
		ht_i       = '0;
		swin_i     = 1'b0;
		lfsr_state = 32'hc4575373;
		exp_hvon   = 1'b0;
		exp_gain   = 1'b0;
		exp_idx    = '0;
		exp_en     = '0;
		exp_alarm  = '0;
		repeat (3) @(posedge CLK1);
		@(negedge CLK1);
		rst_i = 1'b0;
		test_reset();
		test_hv_gain();
		test_adc_mux();
		test_channels();
		test_board_select();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- rtl/taec_top.sv
`timescale 1ns/10ps

module taec_top (
	input  logic                           CLK1,
	input  logic                           rst_i,
	input  logic [taec_pkg::BYTE_W-1:0]    addr_i,      // muxed address/data
	input  logic                           cs_i,
	input  logic                           ale_i,
	input  logic [taec_pkg::BRD_SEL_W-1:0] mod_sel_i,
	input  logic [taec_pkg::BRD_SEL_W-1:0] brd_id_i,
	input  logic [taec_pkg::NUM_CHAN-1:0]  ht_i,
	input  logic                           swin_i,
	output wire  [taec_pkg::DOUT_W-1:0]    dout_o,      // tri-state read-back
	output logic [taec_pkg::NUM_CHAN-1:0]  hv_en_n_o,   // channel enables, active low
	output logic                           hvon_n_o,    // hv supply, active low
	output logic                           hi_gain_n_o, // gain select, active low
	output logic [taec_pkg::MUX_SEL_W-1:0] mux_dout_o   // adc mux select
);

	import taec_pkg::*;

	ni_sample_t          sample;
	cmd_t                cmd;
	logic                sel;
	logic [NUM_CHAN-1:0] ht_sync;
	logic                swin_sync;
	logic                hvon;
	logic [NUM_CHAN-1:0] chan_en;
	logic [NUM_CHAN-1:0] alarm;
	logic                hi_gain;
	logic [CHAN_W-1:0]   mux_idx;

	// ----------------------------------------
	// bus front end
	// ----------------------------------------
	ni_bus_capture ni_bus_capture_i (
		.CLK1       (CLK1),
		.rst_i      (rst_i),
		.addr_i     (addr_i),
		.cs_i       (cs_i),
		.ale_i      (ale_i),
		.mod_sel_i  (mod_sel_i),
		.brd_id_i   (brd_id_i),
		.ht_i       (ht_i),
		.swin_i     (swin_i),
		.sample_o   (sample),
		.sel_o      (sel),
		.ht_sync_o  (ht_sync),
		.swin_sync_o(swin_sync)
	);

	ni_cmd_decode ni_cmd_decode_i (
		.CLK1    (CLK1),
		.rst_i   (rst_i),
		.sample_i(sample),
		.cmd_o   (cmd)
	);

	// ----------------------------------------
	// command consumers
	// ----------------------------------------
	hv_channel_ctrl hv_channel_ctrl_i (
		.CLK1     (CLK1),
		.rst_i    (rst_i),
		.cmd_i    (cmd),
		.ht_sync_i(ht_sync),
		.hvon_o   (hvon),
		.chan_en_o(chan_en),
		.alarm_o  (alarm)
	);

	sense_ctrl sense_ctrl_i (
		.CLK1     (CLK1),
		.rst_i    (rst_i),
		.cmd_i    (cmd),
		.hi_gain_o(hi_gain),
		.mux_sel_o(mux_dout_o),
		.mux_idx_o(mux_idx)
	);

	readback_mux readback_mux_i (
		.CLK1     (CLK1),
		.rst_i    (rst_i),
		.cmd_i    (cmd),
		.sel_i    (sel),
		.hvon_i   (hvon),
		.hi_gain_i(hi_gain),
		.mux_idx_i(mux_idx),
		.alarm_i  (alarm),
		.swin_i   (swin_sync),
		.dout_o   (dout_o)
	);

	// active-low pins
	assign hvon_n_o    = ~hvon;
	assign hv_en_n_o   = ~chan_en;
	assign hi_gain_n_o = ~hi_gain;

endmodule

//--- rtl/readback_mux.sv
`timescale 1ns/10ps

module readback_mux (
	input  logic                          CLK1,
	input  logic                          rst_i,
	input  taec_pkg::cmd_t                cmd_i,
	input  logic                          sel_i,     // board selected
	input  logic                          hvon_i,
	input  logic                          hi_gain_i,
	input  logic [taec_pkg::CHAN_W-1:0]   mux_idx_i,
	input  logic [taec_pkg::NUM_CHAN-1:0] alarm_i,
	input  logic                          swin_i,    // enclosure switch, synced
	output wire  [taec_pkg::DOUT_W-1:0]   dout_o     // tri-state to ni
);

	import taec_pkg::*;

	logic              rd_hit;  // read code seen
	logic              rd_load; // qualified with valid
	logic [DOUT_W-1:0] rd_word; // {0, tag, byte}
	logic [DOUT_W-1:0] word_q;

	// ----------------------------------------
	// word select per read code
	// ----------------------------------------
	always_comb begin
		rd_hit  = 1'b1;
		rd_word = '0;
		case (cmd_i.code)
			CMD_RD_STAT: begin
				rd_word = {1'b0, TAG_STAT, hvon_i, hi_gain_i, 1'b0, mux_idx_i};
			end
			CMD_RD_HT1: begin
				rd_word = {1'b0, TAG_ALARM, alarm_i[7:0]};
			end
			CMD_RD_HT2: begin
				rd_word = {1'b0, TAG_ALARM, alarm_i[15:8]};
			end
			CMD_RD_HT3: begin
				rd_word = {1'b0, TAG_ALARM, 3'b000, swin_i, alarm_i[19:16]};
			end
			default: begin
				rd_hit = 1'b0; // writes and unknown codes
			end
		endcase
	end

	assign rd_load = cmd_i.valid & rd_hit;

	// holds last read until the next one
	always_ff @(posedge CLK1) begin
		if (rst_i) begin
			word_q <= '0;
		end else if (rd_load) begin
			word_q <= rd_word;
		end
	end

	// bus released whenever the board is not addressed
	assign dout_o = sel_i ? word_q : {DOUT_W{1'bz}};

endmodule

//--- rtl/sense_ctrl.sv
`timescale 1ns/10ps

module sense_ctrl (
	input  logic                           CLK1,
	input  logic                           rst_i,
	input  taec_pkg::cmd_t                 cmd_i,
	output logic                           hi_gain_o, // high gain when set
	output logic [taec_pkg::MUX_SEL_W-1:0] mux_sel_o, // adc mux select lines
	output logic [taec_pkg::CHAN_W-1:0]    mux_idx_o  // index actually applied
);

	import taec_pkg::*;

	logic                 gain_wr;
	logic                 mux_wr;
	logic [CHAN_W-1:0]    idx_raw;   // requested index
	logic [CHAN_W-1:0]    idx_app;   // index after range check
	logic                 hi_gain_q;
	logic [MUX_SEL_W-1:0] mux_sel_q;
	logic [CHAN_W-1:0]    mux_idx_q;

	// one-hot mux chip in 5:3, reversed channel in 2:0
	function automatic logic [MUX_SEL_W-1:0] mux_entry(input logic [CHAN_W-1:0] idx);
		mux_entry = {3'b001 << idx[4:3], ~idx[2:0]};
	endfunction

	assign gain_wr = cmd_i.valid && (cmd_i.code == CMD_GAIN);
	assign mux_wr  = cmd_i.valid && (cmd_i.code == CMD_ADC_MUX);
	assign idx_raw = cmd_i.data.raw[CHAN_W-1:0];
	assign idx_app = (idx_raw < NUM_MUX_IN) ? idx_raw : '0; // spare codes fall to 0

	always_ff @(posedge CLK1) begin
		if (rst_i) begin
			hi_gain_q <= 1'b0;         // low gain
			mux_idx_q <= '0;
			mux_sel_q <= mux_entry('0); // 6'b001111
		end else begin
			if (gain_wr) begin
				hi_gain_q <= cmd_i.data.raw[0];
			end
			if (mux_wr) begin
				mux_idx_q <= idx_app;
				mux_sel_q <= mux_entry(idx_app);
			end
		end
	end

	assign hi_gain_o = hi_gain_q;
	assign mux_sel_o = mux_sel_q;
	assign mux_idx_o = mux_idx_q;

endmodule

//--- rtl/hv_channel_ctrl.sv
`timescale 1ns/10ps

module hv_channel_ctrl (
	input  logic                          CLK1,
	input  logic                          rst_i,
	input  taec_pkg::cmd_t                cmd_i,
	input  logic [taec_pkg::NUM_CHAN-1:0] ht_sync_i, // synchronized trips
	output logic                          hvon_o,    // hv supply enable
	output logic [taec_pkg::NUM_CHAN-1:0] chan_en_o, // channel enables, active high
	output logic [taec_pkg::NUM_CHAN-1:0] alarm_o    // latched trip per channel
);

	import taec_pkg::*;

	logic                hvon_q;
	logic [NUM_CHAN-1:0] en_q;
	logic [NUM_CHAN-1:0] alarm_q;
	logic                hvon_wr;   // hv supply write
	logic                chan_wr;   // channel write, any channel
	logic [NUM_CHAN-1:0] wr_sel;    // one-hot channel written
	logic [NUM_CHAN-1:0] wr_en;     // channels written with en high
	logic [NUM_CHAN-1:0] trip;      // trip on an enabled channel
	logic [NUM_CHAN-1:0] en_next;
	logic [NUM_CHAN-1:0] alarm_next;

	assign hvon_wr = cmd_i.valid && (cmd_i.code == CMD_HVON);
	assign chan_wr = cmd_i.valid && (cmd_i.code == CMD_CHAN_EN);

	// ----------------------------------------
	// channel write decode
	// ----------------------------------------
	always_comb begin
		wr_sel = '0;
		if (chan_wr && (cmd_i.data.chan_cmd.chan < NUM_CHAN)) begin
			wr_sel[cmd_i.data.chan_cmd.chan] = 1'b1; // out of range drops out
		end
	end

	assign wr_en = wr_sel & {NUM_CHAN{cmd_i.data.chan_cmd.en}};
	assign trip  = ht_sync_i & en_q; // only live channels can trip

	// trip beats a same-cycle write
	always_comb begin
		en_next    = ((en_q & ~wr_sel) | wr_en) & ~trip;
		alarm_next = (alarm_q & ~wr_en) | trip; // re-enable clears alarm
	end

	// ----------------------------------------
	// state
	// ----------------------------------------
	always_ff @(posedge CLK1) begin
		if (rst_i) begin
			hvon_q  <= 1'b0; // supply off
			en_q    <= '0;   // all channels off
			alarm_q <= '0;
		end else begin
			if (hvon_wr) begin
				hvon_q <= cmd_i.data.raw[0]; // level in bit 0
			end
			en_q    <= en_next;
			alarm_q <= alarm_next;
		end
	end

	assign hvon_o    = hvon_q;
	assign chan_en_o = en_q;
	assign alarm_o   = alarm_q;

endmodule

//--- rtl/ni_cmd_decode.sv
`timescale 1ns/10ps

module ni_cmd_decode (
	input  logic                 CLK1,
	input  logic                 rst_i,
	input  taec_pkg::ni_sample_t sample_i, // synchronized bus sample
	output taec_pkg::cmd_t       cmd_o     // one-cycle command
);

	import taec_pkg::*;

	logic      addr_ph;   // address phase this cycle
	logic      data_ph;   // data phase this cycle
	logic      fire;      // first data after an address
	logic      armed_q;   // address seen, data pending
	cmd_e      code_q;    // latched command code
	logic      valid_q;
	cmd_e      out_code_q;
	bus_byte_t out_data_q;

	assign addr_ph = sample_i.sel & sample_i.ale;
	assign data_ph = sample_i.sel & ~sample_i.ale;
	assign fire    = data_ph & armed_q;

	// ----------------------------------------
	// control, arm and strobe
	// ----------------------------------------
	always_ff @(posedge CLK1) begin
		if (rst_i) begin
			armed_q <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= fire; // high one cycle only
			if (addr_ph) begin
				armed_q <= 1'b1; // new address re-arms
			end else if (fire) begin
				armed_q <= 1'b0; // later data bytes ignored
			end
		end
	end

	// ----------------------------------------
	// payload, qualified by valid_q
	// ----------------------------------------
	always_ff @(posedge CLK1) begin
		if (addr_ph) begin
			code_q <= cmd_e'(sample_i.data.raw); // address byte = command
		end
		if (fire) begin
			out_code_q <= code_q;
			out_data_q <= sample_i.data; // current data byte
		end
	end

	// unknown codes pass through, each consumer picks its own
	assign cmd_o = '{valid: valid_q, code: out_code_q, data: out_data_q};

endmodule

//--- rtl/ni_bus_capture.sv
`timescale 1ns/10ps

module ni_bus_capture (
	input  logic                           CLK1,
	input  logic                           rst_i,
	input  logic [taec_pkg::BYTE_W-1:0]    addr_i,      // muxed address/data
	input  logic                           cs_i,        // chip select
	input  logic                           ale_i,       // address latch enable
	input  logic [taec_pkg::BRD_SEL_W-1:0] mod_sel_i,   // module select from ni
	input  logic [taec_pkg::BRD_SEL_W-1:0] brd_id_i,    // strapped board id
	input  logic [taec_pkg::NUM_CHAN-1:0]  ht_i,        // hv comparator trips
	input  logic                           swin_i,      // enclosure switch
	output taec_pkg::ni_sample_t           sample_o,
	output logic                           sel_o,
	output logic [taec_pkg::NUM_CHAN-1:0]  ht_sync_o,
	output logic                           swin_sync_o
);

	import taec_pkg::*;

	logic                cs_q;    // registered chip select
	logic                match_q; // registered board-id match
	logic                ale_q;
	bus_byte_t           data_q;
	logic [NUM_CHAN-1:0] ht_q;
	logic                swin_q;

	// ----------------------------------------
	// single sync stage on every pin
	// ----------------------------------------
	always_ff @(posedge CLK1) begin
		if (rst_i) begin
			cs_q    <= 1'b0;
			match_q <= 1'b0;
			ale_q   <= 1'b0;
			data_q  <= '0;
			ht_q    <= '0;
			swin_q  <= 1'b0;
		end else begin
			cs_q    <= cs_i;
			match_q <= (mod_sel_i == brd_id_i); // id compare, same stage as cs
			ale_q   <= ale_i;
			data_q  <= addr_i;
			ht_q    <= ht_i;
			swin_q  <= swin_i;
		end
	end

	// board is addressed only with cs and id both true
	assign sel_o = cs_q & match_q;

	assign sample_o = '{sel: sel_o, ale: ale_q, data: data_q};

	assign ht_sync_o   = ht_q;
	assign swin_sync_o = swin_q;

endmodule

//--- rtl/taec_pkg.sv
package taec_pkg;

	// ----------------------------------------
	// widths and counts
	// ----------------------------------------
	localparam int BYTE_W     = 8;  // ni address/data byte
	localparam int DOUT_W     = 12; // read-back bus to ni
	localparam int NUM_CHAN   = 20; // hv channels
	localparam int CHAN_W     = 5;  // channel or mux index
	localparam int MUX_SEL_W  = 6;  // adc mux select lines
	localparam int NUM_MUX_IN = 24; // valid mux inputs
	localparam int BRD_SEL_W  = 2;  // board-id compare

	// ----------------------------------------
	// command codes, taken from the address phase
	// ----------------------------------------
	typedef enum logic [7:0] {
		CMD_HVON    = 8'h01, // hv supply on/off
		CMD_GAIN    = 8'h02, // threshold gain
		CMD_CHAN_EN = 8'h03, // per-channel enable
		CMD_ADC_MUX = 8'h04, // adc input select
		CMD_RD_STAT = 8'h10, // read status byte
		CMD_RD_HT1  = 8'h11, // read alarms 7:0
		CMD_RD_HT2  = 8'h12, // read alarms 15:8
		CMD_RD_HT3  = 8'h13  // read alarms 19:16 + swin
	} cmd_e;

	// read-back tags, bits 10:8 of dout
	localparam logic [2:0] TAG_STAT  = 3'b001;
	localparam logic [2:0] TAG_ALARM = 3'b011;

	// ----------------------------------------
	// bus types
	// ----------------------------------------
	typedef struct packed {
		logic              en;   // bit 7, enable level
		logic [1:0]        pad;  // unused
		logic [CHAN_W-1:0] chan; // channel number
	} chan_cmd_t;

	// data byte seen raw or as a channel command
	typedef union packed {
		logic [BYTE_W-1:0] raw;
		chan_cmd_t         chan_cmd;
	} bus_byte_t;

	// synchronized bus sample
	typedef struct packed {
		logic      sel;  // board selected
		logic      ale;  // high in address phase
		bus_byte_t data; // address or data byte
	} ni_sample_t;

	// one-cycle command to the consumers
	typedef struct packed {
		logic      valid; // strobe
		cmd_e      code;  // latched address byte
		bus_byte_t data;  // data phase byte
	} cmd_t;

endpackage
